/* common/rfifo_pkg.sv */
// ############################################################
// read FIFO shared definitions
// ############################################################
`default_nettype none

package rfifo_pkg;

  // one DMA word carries two DAC samples
  localparam int dma_data_width = 64;
  localparam int dac_data_width = 32;

  typedef logic [dma_data_width-1:0] dma_word_t;
  typedef logic [dac_data_width-1:0] dac_word_t;

  // occupancy in halves, wide enough for any practical depth
  typedef logic [15:0] count_t;

  // msb becomes lsb
  function automatic dma_word_t bitrev_dma(input dma_word_t v);
    return {<<{v}};
  endfunction

  function automatic dac_word_t bitrev_dac(input dac_word_t v);
    return {<<{v}};
  endfunction

endpackage

`default_nettype wire

/* rfifo/dma_reader.sv */
// ############################################################
// DMA read requester
// ############################################################
`timescale 1ns/100ps
`default_nettype none

module dma_reader (
  input  wire logic                 dma_clk,
  input  wire logic                 rst_n,

  // DMA side
  output logic                      dma_rd,
  input  wire rfifo_pkg::dma_word_t dma_rdata,

  // buffer write side
  output logic                      fifo_wr,
  output rfifo_pkg::dma_word_t      fifo_wdata,
  input  wire logic                 fifo_wfull
);

  import rfifo_pkg::*;

  // request follows the full flag one cycle late,
  // the buffer keeps a spare slot for that extra write
  always_ff @(posedge dma_clk or negedge rst_n) begin
    if (!rst_n) begin
      dma_rd <= 1'b0;
    end else begin
      dma_rd <= ~fifo_wfull;
    end
  end

  // data comes back in the request cycle
  assign fifo_wr = dma_rd;

  // stored reversed, the unpacker flips each half back
  assign fifo_wdata = bitrev_dma(dma_rdata);

endmodule

`default_nettype wire

/* rfifo/rfifo_buffer.sv */
// ############################################################
// width converting FIFO buffer
// ############################################################
`timescale 1ns/100ps
`default_nettype none

module rfifo_buffer #(
  parameter int fifo_depth = 8
) (
  input  wire logic                 dma_clk,
  input  wire logic                 rst_n,

  // 64-bit write port
  input  wire logic                 fifo_wr,
  input  wire rfifo_pkg::dma_word_t fifo_wdata,
  output logic                      fifo_wfull,

  // 32-bit read port
  input  wire logic                 fifo_rd,
  output rfifo_pkg::dac_word_t      fifo_rdata,
  output logic                      fifo_rempty
);

  import rfifo_pkg::*;

  localparam int addr_width = $clog2(fifo_depth);

  // a partly read word still holds its slot, so full is
  // fifo_depth-1 slots taken, counted in halves
  localparam count_t full_halves = count_t'(2 * fifo_depth - 3);

  dma_word_t mem [fifo_depth];

  // word write pointer, half read pointer
  logic [addr_width-1:0] wr_ptr;
  logic [addr_width:0]   rd_ptr;
  count_t                half_cnt;

  logic      rd_en;
  dma_word_t rd_word;

  // never read past the last half
  assign rd_en = fifo_rd & ~fifo_rempty;

  assign fifo_rempty = (half_cnt == '0);
  assign fifo_wfull  = (half_cnt >= full_halves);

  // storage
  always_ff @(posedge dma_clk) begin
    if (fifo_wr) begin
      mem[wr_ptr] <= fifo_wdata;
    end
  end

  always_ff @(posedge dma_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (fifo_wr) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // lsb of the read pointer picks the half
  always_ff @(posedge dma_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // +2 per write, -1 per read
  always_ff @(posedge dma_clk or negedge rst_n) begin
    if (!rst_n) begin
      half_cnt <= '0;
    end else begin
      case ({fifo_wr, rd_en})
        2'b10: begin
          half_cnt <= half_cnt + count_t'(2);
        end
        2'b01: begin
          half_cnt <= half_cnt - count_t'(1);
        end
        2'b11: begin
          half_cnt <= half_cnt + count_t'(1);
        end
        default: begin
          half_cnt <= half_cnt;
        end
      endcase
    end
  end

  assign rd_word = mem[rd_ptr[addr_width:1]];

  // lower half first, data valid the cycle after the read
  always_ff @(posedge dma_clk) begin
    if (rd_en) begin
      if (rd_ptr[0]) begin
        fifo_rdata <= rd_word[dma_data_width-1 -: dac_data_width];
      end else begin
        fifo_rdata <= rd_word[dac_data_width-1:0];
      end
    end
  end

endmodule

`default_nettype wire

/* rfifo/dac_unpacker.sv */
// ############################################################
// DAC sample unpacker
// ############################################################
`timescale 1ns/100ps
`default_nettype none

module dac_unpacker (
  input  wire logic                 dma_clk,
  input  wire logic                 rst_n,

  // DAC side
  input  wire logic                 dac_rd,
  output rfifo_pkg::dac_word_t      dac_rdata,
  output logic                      dac_valid,
  output logic                      dac_runf,
  input  wire logic                 dma_runf,

  // buffer read side
  output logic                      fifo_rd,
  input  wire rfifo_pkg::dac_word_t fifo_rdata,
  input  wire logic                 fifo_rempty
);

  import rfifo_pkg::*;

  logic empty_rd;
  logic runf_d1;

  // strobes on an empty buffer are dropped
  assign fifo_rd  = dac_rd & ~fifo_rempty;
  assign empty_rd = dac_rd & fifo_rempty;

  // buffer data lands one cycle after the read
  always_ff @(posedge dma_clk or negedge rst_n) begin
    if (!rst_n) begin
      dac_valid <= 1'b0;
    end else begin
      dac_valid <= fifo_rd;
    end
  end

  // undo the reversal done on the DMA side
  assign dac_rdata = bitrev_dac(fifo_rdata);

  // two stage underflow pipe
  always_ff @(posedge dma_clk or negedge rst_n) begin
    if (!rst_n) begin
      runf_d1  <= 1'b0;
      dac_runf <= 1'b0;
    end else begin
      runf_d1  <= dma_runf | empty_rd;
      dac_runf <= runf_d1;
    end
  end

endmodule

`default_nettype wire

/* hdl/rfifo_top.sv */
// ############################################################
// read FIFO top level
// ############################################################
`timescale 1ns/100ps
`default_nettype none

module rfifo_top #(
  parameter int fifo_depth = 8
) (
  input  wire logic                 dma_clk,
  input  wire logic                 rst_n,

  // DMA side
  output logic                      dma_rd,
  input  wire rfifo_pkg::dma_word_t dma_rdata,
  input  wire logic                 dma_runf,

  // DAC side
  input  wire logic                 dac_rd,
  output rfifo_pkg::dac_word_t      dac_rdata,
  output logic                      dac_valid,
  output logic                      dac_runf
);

  import rfifo_pkg::*;

  logic      fifo_wr;
  dma_word_t fifo_wdata;
  logic      fifo_wfull;
  logic      fifo_rd;
  dac_word_t fifo_rdata;
  logic      fifo_rempty;

  dma_reader i_dma_reader (
    .dma_clk    (dma_clk),
    .rst_n      (rst_n),
    .dma_rd     (dma_rd),
    .dma_rdata  (dma_rdata),
    .fifo_wr    (fifo_wr),
    .fifo_wdata (fifo_wdata),
    .fifo_wfull (fifo_wfull)
  );

  rfifo_buffer #(
    .fifo_depth (fifo_depth)
  ) i_rfifo_buffer (
    .dma_clk     (dma_clk),
    .rst_n       (rst_n),
    .fifo_wr     (fifo_wr),
    .fifo_wdata  (fifo_wdata),
    .fifo_wfull  (fifo_wfull),
    .fifo_rd     (fifo_rd),
    .fifo_rdata  (fifo_rdata),
    .fifo_rempty (fifo_rempty)
  );

  dac_unpacker i_dac_unpacker (
    .dma_clk     (dma_clk),
    .rst_n       (rst_n),
    .dac_rd      (dac_rd),
    .dac_rdata   (dac_rdata),
    .dac_valid   (dac_valid),
    .dac_runf    (dac_runf),
    .dma_runf    (dma_runf),
    .fifo_rd     (fifo_rd),
    .fifo_rdata  (fifo_rdata),
    .fifo_rempty (fifo_rempty)
  );

endmodule

`default_nettype wire

/* testbench/rfifo_checker.sv */
// ############################################################
// read FIFO checker
// ############################################################
`timescale 1ns/100ps
`default_nettype none

module rfifo_checker #(
  parameter int fifo_depth = 8
) (
  input  wire logic        dma_clk,
  input  wire logic        rst_n,
  input  wire logic        dma_rd,
  input  wire logic [63:0] dma_rdata,
  input  wire logic        dma_runf,
  input  wire logic        dac_rd,
  input  wire logic [31:0] dac_rdata,
  input  wire logic        dac_valid,
  input  wire logic        dac_runf,
  input  wire logic [7:0]  test_num,
  input  wire logic [7:0]  exp_runf_cycles,
  input  wire logic        tests_done,
  output int               tests_passed,
  output int               tests_failed,
  output int               error_count
);

  // expected DAC samples in output order
  logic [31:0] model_q [$];
  logic        exp_rd = 1'b0;
  logic        exp_valid = 1'b0;
  logic [31:0] exp_data = '0;
  logic [1:0]  runf_pipe = '0;
  int          cur_test = 0;
  int          cur_exp_runf = 0;
  int          test_errors = 0;
  int          runf_seen = 0;
  logic        closed = 1'b0;

  initial begin
    tests_passed = 0;
    tests_failed = 0;
    error_count  = 0;
  end

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] got);
    if (got !== exp) begin
      $display("[FAIL] test %0d %s exp %0h got %0h", cur_test, name, exp, got);
      test_errors++;
      error_count++;
    end
  endtask

  task automatic finish_test();
    check_value("dac_runf cycles", 64'(cur_exp_runf), 64'(runf_seen));
    if (test_errors == 0) begin
      $display("test %0d passed", cur_test);
      tests_passed++;
    end else begin
      $display("test %0d failed with %0d errors", cur_test, test_errors);
      tests_failed++;
    end
  endtask

  // one cycle of the buffer model
  task automatic step_model();
    logic empty_rd;
    int   slots;
    empty_rd = dac_rd && (model_q.size() == 0);
    // a partly read word still takes its slot
    slots = (model_q.size() + 1) / 2;
    exp_valid = dac_rd && (model_q.size() != 0);
    if (exp_valid) begin
      exp_data = model_q.pop_front();
    end
    // stored reversed, so the original upper half leaves first
    if (dma_rd) begin
      model_q.push_back(dma_rdata[63:32]);
      model_q.push_back(dma_rdata[31:0]);
    end
    exp_rd = !(slots >= fifo_depth - 1);
    runf_pipe = {runf_pipe[0], dma_runf | empty_rd};
    if ((model_q.size() + 1) / 2 > fifo_depth) begin
      $display("test %0d: model buffer holds more words than its depth", cur_test);
      test_errors++;
      error_count++;
    end
  endtask

  // outputs are settled at the falling edge
  always @(negedge dma_clk) begin
    if (!rst_n) begin
      model_q.delete();
      exp_rd    = 1'b0;
      exp_valid = 1'b0;
      runf_pipe = '0;
    end else if (!closed) begin
      if (int'(test_num) != cur_test || tests_done) begin
        if (cur_test != 0) begin
          finish_test();
        end
        cur_test     = int'(test_num);
        cur_exp_runf = int'(exp_runf_cycles);
        test_errors  = 0;
        runf_seen    = 0;
        closed       = tests_done;
      end
      if (!closed) begin
        check_value("dma_rd", 64'(exp_rd), 64'(dma_rd));
        check_value("dac_valid", 64'(exp_valid), 64'(dac_valid));
        if (exp_valid) begin
          check_value("dac_rdata", 64'(exp_data), 64'(dac_rdata));
        end
        check_value("dac_runf", 64'(runf_pipe[1]), 64'(dac_runf));
        if (dac_runf) begin
          runf_seen++;
        end
        step_model();
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/rfifo_tb.sv */
// ############################################################
// read FIFO testbench
// ############################################################
`timescale 1ns/100ps
`default_nettype none

module rfifo_tb;

  localparam int fifo_depth = 8;
  localparam int num_tests  = 7;

  // DAC read duty
  localparam int duty_never  = 0;
  localparam int duty_always = 1;
  localparam int duty_alt    = 2;

  // reset and empty reads, data order, bit extremes, back-pressure, drain, DMA underflow
  int          row_cycles     [num_tests] = '{12, 40, 20, 20, 30, 40, 24};
  int          row_duty       [num_tests] = '{duty_always, duty_always, duty_alt, duty_alt,
                                              duty_never, duty_always, duty_always};
  logic        row_use_pat    [num_tests] = '{0, 0, 1, 1, 0, 0, 0};
  logic [63:0] row_pattern    [num_tests] = '{64'h0, 64'h0, 64'h1, 64'h8000_0000_0000_0000,
                                              64'h0, 64'h0, 64'h0};
  int          row_runf_start [num_tests] = '{0, 0, 0, 0, 0, 0, 5};
  int          row_runf_len   [num_tests] = '{0, 0, 0, 0, 0, 0, 5};
  // two empty reads right after reset, five cycles of DMA underflow
  int          row_exp_runf   [num_tests] = '{2, 0, 0, 0, 0, 0, 5};

  logic        dma_clk = 1'b0;
  logic        rst_n;
  logic        dma_rd;
  logic [63:0] dma_rdata;
  logic        dma_runf;
  logic        dac_rd;
  logic [31:0] dac_rdata;
  logic        dac_valid;
  logic        dac_runf;
  logic [7:0]  test_num;
  logic [7:0]  exp_runf_cycles;
  logic        tests_done;
  int          tests_passed;
  int          tests_failed;
  int          error_count;
  logic [31:0] lcg_state = 32'haf02;
  int          cycle_cnt = 0;
  int          timeout_limit = 0;

  always #4 dma_clk = ~dma_clk;

  rfifo_top #(
    .fifo_depth (fifo_depth)
  ) dut (
    .dma_clk   (dma_clk),
    .rst_n     (rst_n),
    .dma_rd    (dma_rd),
    .dma_rdata (dma_rdata),
    .dma_runf  (dma_runf),
    .dac_rd    (dac_rd),
    .dac_rdata (dac_rdata),
    .dac_valid (dac_valid),
    .dac_runf  (dac_runf)
  );

  rfifo_checker #(
    .fifo_depth (fifo_depth)
  ) i_checker (
    .dma_clk         (dma_clk),
    .rst_n           (rst_n),
    .dma_rd          (dma_rd),
    .dma_rdata       (dma_rdata),
    .dma_runf        (dma_runf),
    .dac_rd          (dac_rd),
    .dac_rdata       (dac_rdata),
    .dac_valid       (dac_valid),
    .dac_runf        (dac_runf),
    .test_num        (test_num),
    .exp_runf_cycles (exp_runf_cycles),
    .tests_done      (tests_done),
    .tests_passed    (tests_passed),
    .tests_failed    (tests_failed),
    .error_count     (error_count)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_word(output logic [63:0] w);
    lcg_state = lcg_next(lcg_state);
    w[63:32] = lcg_state;
    lcg_state = lcg_next(lcg_state);
    w[31:0] = lcg_state;
  endtask

  // inputs change 1 ns after the rising edge
  task automatic run_row(input int r);
    int          c;
    logic [63:0] w;
    test_num = 8'(r + 1);
    exp_runf_cycles = 8'(row_exp_runf[r]);
    for (c = 0; c < row_cycles[r]; c++) begin
      dac_rd = (row_duty[r] == duty_always) || (row_duty[r] == duty_alt && c % 2 == 0);
      dma_runf = (c >= row_runf_start[r]) && (c < row_runf_start[r] + row_runf_len[r]);
      // a new word answers each request
      if (dma_rd) begin
        if (row_use_pat[r]) begin
          dma_rdata = row_pattern[r];
        end else begin
          draw_word(w);
          dma_rdata = w;
        end
      end
      @(posedge dma_clk);
      #1;
    end
  endtask

  always @(posedge dma_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    int r;
    timeout_limit = 100;
    for (r = 0; r < num_tests; r++) begin
      timeout_limit += row_cycles[r];
    end
    rst_n           = 1'b0;
    dma_rdata       = '0;
    dma_runf        = 1'b0;
    dac_rd          = 1'b0;
    test_num        = '0;
    exp_runf_cycles = '0;
    tests_done      = 1'b0;
    repeat (8) @(posedge dma_clk);
    #1;
    rst_n = 1'b1;
    for (r = 0; r < num_tests; r++) begin
      run_row(r);
    end
    dac_rd     = 1'b0;
    dma_runf   = 1'b0;
    tests_done = 1'b1;
    repeat (2) @(posedge dma_clk);
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             num_tests, tests_passed, tests_failed, error_count);
    if (tests_passed == num_tests && tests_failed == 0 && error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
common/rfifo_pkg.sv
rfifo/dma_reader.sv
rfifo/rfifo_buffer.sv
rfifo/dac_unpacker.sv
hdl/rfifo_top.sv
testbench/rfifo_checker.sv
testbench/rfifo_tb.sv

/* Makefile */
# Verilator build for the read FIFO

TOP = rfifo_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

# RTL only, all warnings on
lint:
	verilator --lint-only -Wall --top-module rfifo_top \
		common/rfifo_pkg.sv rfifo/dma_reader.sv rfifo/rfifo_buffer.sv \
		rfifo/dac_unpacker.sv hdl/rfifo_top.sv

# build and run, then look for the pass line in the log
sim:
	verilator --binary --timing -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
